// File: include/dz_rx_consts.svh
// Sizing constants for the DZ receive path: line count, silo geometry and host credits
// Included by every file that needs one of these sizes
`ifndef DZ_RX_CONSTS_SVH
`define DZ_RX_CONSTS_SVH

// Number of serial lines scanned
`define DZ_NUM_LINES 8

// Character width on every line
`define DZ_CHAR_W 8

// Silo entries
// Full is flagged one entry short of this
`define DZ_SILO_DEPTH 64

// Interrupt level with silo alarm enabled
`define DZ_ALARM_LEVEL 16

// Output credits granted by the host at reset
`define DZ_HOST_CREDITS 4

`endif

// File: design/dz_line_pkg.sv
// Line-side types: line number, received character and the silo entry layout
// Imported by the scanner, the silo and anything that looks at silo entries
`include "dz_rx_consts.svh"

package dz_line_pkg;

   // Bits needed to name a line
   localparam int LINE_W = $clog2(`DZ_NUM_LINES);

   // Line number
   typedef logic [LINE_W-1:0] line_num_t;

   // One received character
   typedef logic [`DZ_CHAR_W-1:0] rx_char_t;

   // Silo entry
   // Line number on top, character below (11 bits for 8 lines)
   typedef struct packed
   {
      line_num_t line;
      rx_char_t  data;
   } silo_entry_t;

endpackage

// File: design/dz_host_pkg.sv
// Host-side types: command opcodes and the output state machine encoding
// Imported by the host port and the top level
package dz_host_pkg;

   // Host command opcodes
   typedef enum logic [1:0]
   {
      CMD_ALARM_ON  = 2'd0,
      CMD_ALARM_OFF = 2'd1,
      CMD_FLUSH     = 2'd2
   } host_cmd_e;

   // Output side states
   // SETTLE gives the silo read register one cycle to catch up
   typedef enum logic [1:0]
   {
      HP_IDLE   = 2'd0,
      HP_SETTLE = 2'd1,
      HP_SEND   = 2'd2
   } host_state_e;

endpackage

// File: design/dz_rx_scanner.sv
// Input side of the receive path: one holding buffer per line, round-robin scan into the silo
// Each line owns one credit; it comes back the cycle after that line's character is written
`timescale 1ns/100ps
`include "dz_rx_consts.svh"

module dz_rx_scanner
   import dz_line_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic [`DZ_NUM_LINES-1:0]     line_valid,
   input  rx_char_t [`DZ_NUM_LINES-1:0] line_data,
   output logic [`DZ_NUM_LINES-1:0]     line_credit,
   output logic                         silo_wr,
   output silo_entry_t                  silo_din,
   input  logic                         silo_full
);

   ////////////////////////////////////////////////////////////
   // Holding buffers
   ////////////////////////////////////////////////////////////

   // One character slot per line
   logic [`DZ_NUM_LINES-1:0] buf_full;
   rx_char_t [`DZ_NUM_LINES-1:0] buf_char;

   // Scan state
   line_num_t last_line;
   line_num_t win_line;
   logic      win_found;
   logic      wr_fire;

   // Character registers
   // Loaded only when the line hands over a character
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `DZ_NUM_LINES; i++)
      begin
         if (line_valid[i])
            buf_char[i] <= line_data[i];
      end
   end

   // Occupancy flags
   // A line only sends while holding its credit, so set never meets a full slot
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         buf_full <= '0;
      else
      begin
         for (int i = 0; i < `DZ_NUM_LINES; i++)
         begin
            if (line_valid[i])
               buf_full[i] <= 1'b1;
            else if (wr_fire && win_line == line_num_t'(i))
               buf_full[i] <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Round-robin scan
   ////////////////////////////////////////////////////////////

   // Search starts just past the last winner
   // First occupied slot found wins
   always_comb
   begin
      int unsigned idx;
      win_found = 1'b0;
      win_line  = last_line;
      for (int k = 1; k <= `DZ_NUM_LINES; k++)
      begin
         idx = (int'(last_line) + k) % `DZ_NUM_LINES;
         if (!win_found && buf_full[idx])
         begin
            win_found = 1'b1;
            win_line  = line_num_t'(idx);
         end
      end
   end

   // Write only into a silo with room
   assign wr_fire = win_found & ~silo_full;

   // Last winner
   // Moves only on an actual write so a stalled line keeps its turn
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         last_line <= line_num_t'(`DZ_NUM_LINES - 1);
      else if (wr_fire)
         last_line <= win_line;
   end

   ////////////////////////////////////////////////////////////
   // Silo write and credit return
   ////////////////////////////////////////////////////////////

   // Entry tagged with its line number
   assign silo_wr       = wr_fire;
   assign silo_din.line = win_line;
   assign silo_din.data = buf_char[win_line];

   // Credit pulse
   // Lands in the cycle after the write edge, same cycle the new depth shows
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         line_credit <= '0;
      else if (wr_fire)
         line_credit <= `DZ_NUM_LINES'(1) << win_line;
      else
         line_credit <= '0;
   end

endmodule

// File: design/dz_silo.sv
// Receive silo: 64-entry dual-port FIFO with depth count, full, empty and alarm flags
// Written by the scanner, read by the host port; flush empties it in one cycle
`timescale 1ns/100ps
`include "dz_rx_consts.svh"

module dz_silo
   import dz_line_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        flush,
   input  logic        wr,
   input  silo_entry_t din,
   input  logic        rd,
   output silo_entry_t dout,
   output logic        full,
   output logic        alarm,
   output logic        empty
);

   // Pointer and depth width
   localparam int PTR_W = $clog2(`DZ_SILO_DEPTH);

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] depth;

   // Qualified requests
   // Writes into a full silo and reads from an empty one are ignored
   logic wr_ok;
   logic rd_ok;

   assign wr_ok = wr & ~full;
   assign rd_ok = rd & ~empty;

   ////////////////////////////////////////////////////////////
   // Pointers
   ////////////////////////////////////////////////////////////

   // Flush beats any write or read in the same cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else if (flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Depth
   ////////////////////////////////////////////////////////////

   // Read and write together leave it alone
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         depth <= '0;
      else if (flush)
         depth <= '0;
      else if (rd_ok && !wr_ok)
         depth <= depth - 1'b1;
      else if (wr_ok && !rd_ok)
         depth <= depth + 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // Dual-port array
   ////////////////////////////////////////////////////////////

   silo_entry_t mem [`DZ_SILO_DEPTH];

   // Read register follows the head every cycle
   // New head is visible one cycle after the pointer moves
   always_ff @(posedge clk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= din;
      dout <= mem[rd_ptr];
   end

   // Flags
   assign empty = (depth == '0);
   assign full  = (depth == PTR_W'(`DZ_SILO_DEPTH - 1));
   assign alarm = (depth > PTR_W'(`DZ_ALARM_LEVEL));

endmodule

// File: design/dz_host_port.sv
// Output side: decodes host commands, counts host credits and pops silo entries to the host
// Also produces the registered receive interrupt from the silo flags
`timescale 1ns/100ps
`include "dz_rx_consts.svh"

module dz_host_port
   import dz_line_pkg::*;
   import dz_host_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        host_cmd_valid,
   input  host_cmd_e   host_cmd,
   input  logic        host_credit,
   output logic        out_valid,
   output silo_entry_t out_entry,
   output logic        irq,
   input  silo_entry_t silo_dout,
   input  logic        silo_empty,
   input  logic        silo_alarm,
   output logic        silo_rd,
   output logic        silo_flush
);

   // Credit counter range 0 .. DZ_HOST_CREDITS
   localparam int CRED_W = $clog2(`DZ_HOST_CREDITS + 1);
   localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`DZ_HOST_CREDITS);

   host_state_e      state;
   host_state_e      state_nxt;
   logic [CRED_W-1:0] credits;
   logic             alarm_en;
   logic             cmd_flush;
   logic             send;

   ////////////////////////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////////////////////////

   assign cmd_flush = host_cmd_valid && (host_cmd == CMD_FLUSH);

   // Alarm enable
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         alarm_en <= 1'b0;
      else if (host_cmd_valid && host_cmd == CMD_ALARM_ON)
         alarm_en <= 1'b1;
      else if (host_cmd_valid && host_cmd == CMD_ALARM_OFF)
         alarm_en <= 1'b0;
   end

   // Flush pulse
   // Silo clears on the edge after the command
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         silo_flush <= 1'b0;
      else
         silo_flush <= cmd_flush;
   end

   ////////////////////////////////////////////////////////////
   // Host credits
   ////////////////////////////////////////////////////////////

   // Return and spend in one cycle cancel out
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         credits <= CRED_MAX;
      else if (host_credit && !send && credits != CRED_MAX)
         credits <= credits + 1'b1;
      else if (send && !host_credit)
         credits <= credits - 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // Output FSM
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      state_nxt = state;
      case (state)
         // Wait for data and a credit, and stay put while a flush is landing
         HP_IDLE:
            if (!silo_empty && credits != '0 && !silo_flush)
               state_nxt = HP_SETTLE;
         // Read register now holds the head entry
         HP_SETTLE:
            state_nxt = HP_SEND;
         // One entry out, back to idle
         HP_SEND:
            state_nxt = HP_IDLE;
         default:
            state_nxt = HP_IDLE;
      endcase
   end

   // Flush command drops any pop in progress
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         state <= HP_IDLE;
      else if (cmd_flush)
         state <= HP_IDLE;
      else
         state <= state_nxt;
   end

   // Present and pop in the same cycle
   assign send      = (state == HP_SEND);
   assign out_valid = send;
   assign out_entry = silo_dout;
   assign silo_rd   = send;

   ////////////////////////////////////////////////////////////
   // Interrupt
   ////////////////////////////////////////////////////////////

   // Previous-cycle flags
   // Alarm mode waits for the alarm level, otherwise any entry will do
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         irq <= 1'b0;
      else if (alarm_en)
         irq <= silo_alarm;
      else
         irq <= ~silo_empty;
   end

endmodule

// File: design/dz_rx_top.sv
// Top of the DZ receive path: scanner feeding the silo, host port draining it
// Wiring only; all behaviour lives in the three child blocks
`timescale 1ns/100ps
`include "dz_rx_consts.svh"

module dz_rx_top
   import dz_line_pkg::*;
   import dz_host_pkg::*;
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic [`DZ_NUM_LINES-1:0]     line_valid,
   input  rx_char_t [`DZ_NUM_LINES-1:0] line_data,
   output logic [`DZ_NUM_LINES-1:0]     line_credit,
   input  logic                         host_cmd_valid,
   input  host_cmd_e                    host_cmd,
   input  logic                         host_credit,
   output logic                         out_valid,
   output silo_entry_t                  out_entry,
   output logic                         irq
);

   ////////////////////////////////////////////////////////////
   // Internal links
   ////////////////////////////////////////////////////////////

   // Scanner to silo
   logic        silo_wr;
   silo_entry_t silo_din;
   logic        silo_full;

   // Silo to host port
   silo_entry_t silo_dout;
   logic        silo_empty;
   logic        silo_alarm;
   logic        silo_rd;
   logic        silo_flush;

   // Input side
   dz_rx_scanner i_scanner
   (
      .clk         (clk),
      .rst         (rst),
      .line_valid  (line_valid),
      .line_data   (line_data),
      .line_credit (line_credit),
      .silo_wr     (silo_wr),
      .silo_din    (silo_din),
      .silo_full   (silo_full)
   );

   // Silo
   dz_silo i_silo
   (
      .clk   (clk),
      .rst   (rst),
      .flush (silo_flush),
      .wr    (silo_wr),
      .din   (silo_din),
      .rd    (silo_rd),
      .dout  (silo_dout),
      .full  (silo_full),
      .alarm (silo_alarm),
      .empty (silo_empty)
   );

   // Output side
   dz_host_port i_host_port
   (
      .clk            (clk),
      .rst            (rst),
      .host_cmd_valid (host_cmd_valid),
      .host_cmd       (host_cmd),
      .host_credit    (host_credit),
      .out_valid      (out_valid),
      .out_entry      (out_entry),
      .irq            (irq),
      .silo_dout      (silo_dout),
      .silo_empty     (silo_empty),
      .silo_alarm     (silo_alarm),
      .silo_rd        (silo_rd),
      .silo_flush     (silo_flush)
   );

endmodule

// File: testbench/dz_rx_sva.sv
// Protocol checks for the receive path: line credits, host credits and silo flags
// Bound into dz_rx_top by the bind statement at the end of this file
`timescale 1ns/100ps
`include "dz_rx_consts.svh"

module dz_rx_sva
(
   input logic                     clk,
   input logic                     rst,
   input logic [`DZ_NUM_LINES-1:0] line_valid,
   input logic [`DZ_NUM_LINES-1:0] line_credit,
   input logic                     host_credit,
   input logic                     out_valid,
   input logic                     silo_full,
   input logic                     silo_empty
);

   ////////////////////////////////////////////////////////////
   // Credit bookkeeping
   ////////////////////////////////////////////////////////////

   // Credit currently held by each line
   logic [`DZ_NUM_LINES-1:0] held;

   // Host credits granted so far, reset grant included
   int unsigned granted;
   // Entries presented to the host so far
   int unsigned sent;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         held    <= '1;
         granted <= `DZ_HOST_CREDITS;
         sent    <= 0;
      end
      else
      begin
         held <= (held & ~line_valid) | line_credit;
         if (host_credit)
            granted <= granted + 1;
         if (out_valid)
            sent <= sent + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Line side
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `DZ_NUM_LINES; i++)
   begin : g_line
      // Valid spends the credit the line holds
      a_valid_with_credit: assert property (@(posedge clk) disable iff (rst)
         line_valid[i] |-> held[i])
         else $error("line %0d sent a character without holding a credit", i);

      // At most one credit outstanding per line
      a_single_credit: assert property (@(posedge clk) disable iff (rst)
         line_credit[i] |-> !held[i])
         else $error("line %0d was given a second credit", i);
   end

   ////////////////////////////////////////////////////////////
   // Host side and silo flags
   ////////////////////////////////////////////////////////////

   // Every entry out must be covered by a host credit
   a_host_credit: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> (sent < granted))
      else $error("entry sent to the host without a credit");

   a_full_empty: assert property (@(posedge clk) disable iff (rst)
      !(silo_full && silo_empty))
      else $error("silo reports full and empty together");

endmodule

bind dz_rx_top dz_rx_sva i_sva
(
   .clk         (clk),
   .rst         (rst),
   .line_valid  (line_valid),
   .line_credit (line_credit),
   .host_credit (host_credit),
   .out_valid   (out_valid),
   .silo_full   (silo_full),
   .silo_empty  (silo_empty)
);

// File: testbench/dz_rx_tb.sv
// Testbench for the DZ receive path: LFSR line traffic, host credit model and scoreboard
// Runs random, back-pressure, flush and resync phases against dz_rx_top
`timescale 1ns/100ps
`include "dz_rx_consts.svh"

module dz_rx_tb
   import dz_line_pkg::*;
   import dz_host_pkg::*;
();

   // Characters per phase
   localparam int PH1_CHARS   = 200;
   localparam int FILL_CHARS  = `DZ_SILO_DEPTH - 1 + `DZ_NUM_LINES + `DZ_HOST_CREDITS;
   localparam int PH3_CHARS   = 150;
   localparam int FLUSH_CHARS = 24;
   localparam int PH5_CHARS   = 150;
   localparam int TOTAL_CHARS = PH1_CHARS + FILL_CHARS + PH3_CHARS + FLUSH_CHARS + PH5_CHARS;
   // Cycles the full silo is held under back-pressure
   localparam int BP_HOLD     = 20;
   // Run limit: 3 cycles per character plus fill, flush and margin
   localparam int TIMEOUT_CYCLES = 3 * TOTAL_CHARS + (FILL_CHARS + BP_HOLD) + 100 + 2000;

   logic                         clk;
   logic                         rst;
   logic [`DZ_NUM_LINES-1:0]     line_valid;
   rx_char_t [`DZ_NUM_LINES-1:0] line_data;
   logic [`DZ_NUM_LINES-1:0]     line_credit;
   logic                         host_cmd_valid;
   host_cmd_e                    host_cmd;
   logic                         host_credit;
   logic                         out_valid;
   silo_entry_t                  out_entry;
   logic                         irq;

   // Stimulus state
   logic [31:0]              lfsr;
   logic [`DZ_NUM_LINES-1:0] line_cred;
   int sent_seq [`DZ_NUM_LINES];
   int exp_seq [`DZ_NUM_LINES];
   int budget;
   logic send_all;
   logic hold_credits;
   int owed;
   int ret_delay;
   logic cmd_req;
   host_cmd_e cmd_code;
   // Reference model
   int md;
   logic irq_exp;
   logic alarm_mode;
   logic flush_pending;
   logic bp_check;
   int cycles;

   dz_rx_top i_dut
   (
      .clk            (clk),
      .rst            (rst),
      .line_valid     (line_valid),
      .line_data      (line_data),
      .line_credit    (line_credit),
      .host_cmd_valid (host_cmd_valid),
      .host_cmd       (host_cmd),
      .host_credit    (host_credit),
      .out_valid      (out_valid),
      .out_entry      (out_entry),
      .irq            (irq)
   );

   always #10 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int b = 0; b < n; b++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // Scoreboard: line tag picks the expected sequence value
   task automatic check_entry;
      int l;
      l = int'(out_entry.line);
      assert (exp_seq[l] < sent_seq[l])
         else stop_on_error($sformatf("Line %0d delivered a character it never sent", l));
      assert (out_entry.data == rx_char_t'(exp_seq[l]))
         else stop_on_error($sformatf("FAILED t=%0t out_entry.data got %h expected %h",
                                      $time, out_entry.data, rx_char_t'(exp_seq[l])));
      exp_seq[l]++;
      owed++;
   endtask

   // Lines send only while holding their credit
   task automatic drive_lines;
      logic go;
      for (int i = 0; i < `DZ_NUM_LINES; i++)
      begin
         go = (rand_bits(3) == 32'd7) || send_all;
         if (budget > 0 && line_cred[i] && go)
         begin
            line_valid[i] <= 1'b1;
            line_data[i]  <= rx_char_t'(sent_seq[i]);
            sent_seq[i]++;
            line_cred[i] = 1'b0;
            budget--;
         end
         else
            line_valid[i] <= 1'b0;
      end
   endtask

   // Host hands back one credit after a short random delay
   task automatic return_host_credit;
      if (owed > 0 && !hold_credits && ret_delay == 0)
      begin
         host_credit <= 1'b1;
         owed--;
         ret_delay = int'(rand_bits(2));
      end
      else
      begin
         host_credit <= 1'b0;
         if (ret_delay > 0)
            ret_delay--;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Per-cycle model, checks and drive
   ////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin : model
      int cur;
      if (!rst)
      begin
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            stop_on_error($sformatf("Timeout after %0d cycles", cycles));
         assert (irq == irq_exp)
            else stop_on_error($sformatf("FAILED t=%0t irq got %b expected %b",
                                         $time, irq, irq_exp));
         // Depth seen by the silo this cycle
         cur     = md + $countones(line_credit);
         irq_exp = alarm_mode ? (cur > `DZ_ALARM_LEVEL) : (cur != 0);
         md      = cur - (out_valid ? 1 : 0);
         if (flush_pending)
            md = 0;
         flush_pending = host_cmd_valid && host_cmd == CMD_FLUSH;
         if (host_cmd_valid && host_cmd == CMD_ALARM_ON)
            alarm_mode = 1'b1;
         else if (host_cmd_valid && host_cmd == CMD_ALARM_OFF)
            alarm_mode = 1'b0;
         if (out_valid)
            check_entry();
         if (bp_check)
            assert (line_credit == '0 && !out_valid)
               else stop_on_error("Full silo still returned a line credit or sent an entry");
         line_cred = line_cred | line_credit;
         drive_lines();
         return_host_credit();
         if (cmd_req)
         begin
            host_cmd_valid <= 1'b1;
            host_cmd       <= cmd_code;
            cmd_req = 1'b0;
         end
         else
            host_cmd_valid <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Phase sequencing
   ////////////////////////////////////////////////////////////

   task automatic send_cmd(input host_cmd_e c);
      @(negedge clk);
      cmd_code = c;
      cmd_req  = 1'b1;
      while (cmd_req)
         @(negedge clk);
   endtask

   task automatic run_traffic(input int n);
      @(negedge clk);
      budget = n;
      while (budget > 0)
         @(negedge clk);
   endtask

   function automatic logic drained();
      logic ok;
      ok = (md == 0) && (line_cred == '1);
      for (int i = 0; i < `DZ_NUM_LINES; i++)
         ok = ok && (exp_seq[i] == sent_seq[i]);
      return ok;
   endfunction

   initial
   begin
      clk            = 1'b0;
      rst            = 1'b1;
      line_valid     = '0;
      line_data      = '0;
      host_cmd_valid = 1'b0;
      host_cmd       = CMD_ALARM_OFF;
      host_credit    = 1'b0;
      lfsr           = 32'h0584_4edf;
      line_cred      = '1;
      budget         = 0;
      send_all       = 1'b0;
      hold_credits   = 1'b0;
      owed           = 0;
      ret_delay      = 0;
      cmd_req        = 1'b0;
      cmd_code       = CMD_ALARM_OFF;
      md             = 0;
      irq_exp        = 1'b0;
      alarm_mode     = 1'b0;
      flush_pending  = 1'b0;
      bp_check       = 1'b0;
      cycles         = 0;
      for (int i = 0; i < `DZ_NUM_LINES; i++)
      begin
         sent_seq[i] = 0;
         exp_seq[i]  = 0;
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      // Random traffic, alarm off
      run_traffic(PH1_CHARS);

      // Back-pressure with alarm on until the silo is full and the host is out of credits
      send_cmd(CMD_ALARM_ON);
      hold_credits = 1'b1;
      send_all     = 1'b1;
      budget       = FILL_CHARS;
      while (md < `DZ_SILO_DEPTH - 1 || owed < `DZ_HOST_CREDITS)
         @(negedge clk);
      budget   = 0;
      bp_check = 1'b1;
      repeat (BP_HOLD) @(negedge clk);
      bp_check     = 1'b0;
      send_all     = 1'b0;
      hold_credits = 1'b0;
      run_traffic(PH3_CHARS);
      send_cmd(CMD_ALARM_OFF);
      while (!drained())
         @(negedge clk);

      // Load the silo with the host starved, then flush
      hold_credits = 1'b1;
      run_traffic(FLUSH_CHARS);
      while (owed < `DZ_HOST_CREDITS || line_cred != '1)
         @(negedge clk);
      repeat (2) @(negedge clk);
      send_cmd(CMD_FLUSH);
      repeat (3) @(negedge clk);
      assert (irq == 1'b0)
         else stop_on_error($sformatf("FAILED t=%0t irq got %b expected 0 after flush",
                                      $time, irq));
      // Flushed characters will never arrive
      for (int i = 0; i < `DZ_NUM_LINES; i++)
         exp_seq[i] = sent_seq[i];

      // Resume on all lines
      hold_credits = 1'b0;
      run_traffic(PH5_CHARS);
      while (!drained())
         @(negedge clk);
      repeat (10) @(negedge clk);
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: build.f
+incdir+include
design/dz_line_pkg.sv
design/dz_host_pkg.sv
design/dz_rx_scanner.sv
design/dz_silo.sv
design/dz_host_port.sv
design/dz_rx_top.sv
testbench/dz_rx_sva.sv
testbench/dz_rx_tb.sv

// File: Makefile
# Verilator build and run of the DZ receive testbench
# The log decides the result: any fail line or a missing pass line fails the target

.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module dz_rx_tb -f build.f
	-./obj_dir/Vdz_rx_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
